/* fc_subsystem.f */
source/fc_pkg.sv
source/tcdm_bus_if.sv
source/fc_demux.sv
source/event_fifo.sv
source/irq_pending.sv
source/irq_ctrl_fsm.sv
source/sleep_timer.sv
source/fc_subsystem.sv
tb/tb_fc_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fc_subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fc_subsystem -f fc_subsystem.f -o sim_fc_subsystem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_fc_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
    exit 0
fi
exit 1

/* source/event_fifo.sv */
// Peripheral event ID FIFO
`timescale 1ns/10ps

module event_fifo import fc_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      push_i,
    input  event_id_t data_i,
    input  logic      pop_i,
    output logic      not_empty_o,
    output event_id_t head_o,
    output logic      fulln_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    event_id_t        mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    assign fulln_o     = (count_q != (PTR_W+1)'(FIFO_DEPTH));
    assign not_empty_o = (count_q != '0);
    assign head_o      = mem_q[rd_ptr_q];

    // Push while full is dropped
    assign do_push = push_i & fulln_o;
    assign do_pop  = pop_i & not_empty_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Pointers wrap on their own, depth is a power of two
            count_q <= count_q + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> not_empty_o);

endmodule

/* source/fc_demux.sv */
// Core data bus demultiplexer
`timescale 1ns/10ps

module fc_demux import fc_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    tcdm_bus_if.slave  slave_port,
    tcdm_bus_if.master l2_port,
    tcdm_bus_if.master scm_port
);

    logic is_scm;
    logic accept;
    logic sel_scm_q;

    // Primary range or alias range goes to the SCM
    assign is_scm = ((slave_port.add >= SCM_START_ADDR) &&
                     (slave_port.add <  SCM_END_ADDR)) ||
                    ((slave_port.add >= ALIAS_SCM_START_ADDR) &&
                     (slave_port.add <  ALIAS_SCM_END_ADDR));

    // Only one port ever sees the request
    assign l2_port.req    = slave_port.req & ~is_scm;
    assign scm_port.req   = slave_port.req & is_scm;

    assign l2_port.add    = slave_port.add;
    assign l2_port.wen    = slave_port.wen;
    assign l2_port.wdata  = slave_port.wdata;
    assign l2_port.be     = slave_port.be;

    assign scm_port.add   = slave_port.add;
    assign scm_port.wen   = slave_port.wen;
    assign scm_port.wdata = slave_port.wdata;
    assign scm_port.be    = slave_port.be;

    // Core stalls until the selected memory grants
    assign slave_port.gnt = is_scm ? (scm_port.req & scm_port.gnt)
                                   : (l2_port.req & l2_port.gnt);

    assign accept = slave_port.req & slave_port.gnt;

    // Remember which port took the request
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_scm_q <= 1'b0;
        end else if (accept) begin
            sel_scm_q <= is_scm;
        end
    end

    assign slave_port.r_valid = sel_scm_q ? scm_port.r_valid : l2_port.r_valid;
    assign slave_port.r_rdata = sel_scm_q ? scm_port.r_rdata : l2_port.r_rdata;

    // Each response comes back on the port that took the request
    a_rvalid_from_sel : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(l2_port.r_valid && sel_scm_q) && !(scm_port.r_valid && !sel_scm_q));

    // Memories answer one cycle after acceptance, never unprompted
    a_rvalid_after_accept : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (l2_port.r_valid || scm_port.r_valid) |-> $past(accept));

endmodule

/* source/fc_pkg.sv */
// Fabric controller shared definitions

package fc_pkg;

    // **********************************************************
    // Address map
    // **********************************************************

    // Lower bounds included, upper bounds excluded
    localparam logic [31:0] SCM_START_ADDR       = 32'h1C00_0000;
    localparam logic [31:0] SCM_END_ADDR         = 32'h1C00_8000;
    localparam logic [31:0] ALIAS_SCM_START_ADDR = 32'h1000_0000;
    localparam logic [31:0] ALIAS_SCM_END_ADDR   = 32'h1000_8000;

    // **********************************************************
    // Widths and ID types
    // **********************************************************

    localparam int ADDR_WIDTH     = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int EVENT_ID_WIDTH = 8;
    localparam int IRQ_ID_WIDTH   = 5;

    // Peripheral event ID as queued by the FIFO
    typedef logic [EVENT_ID_WIDTH-1:0] event_id_t;

    // Interrupt line number seen by the core
    typedef logic [IRQ_ID_WIDTH-1:0] irq_id_t;

    // Interrupt line reserved for queued peripheral events
    localparam irq_id_t FIFO_IRQ_ID = irq_id_t'(26);

endpackage

/* source/fc_subsystem.sv */
// Fabric controller subsystem top level
`timescale 1ns/10ps

module fc_subsystem import fc_pkg::*; #(
    parameter int FIFO_DEPTH  = 4,
    parameter int SLEEP_DELAY = 8
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    core_req_i,
    input  logic [ADDR_WIDTH-1:0]   core_addr_i,
    input  logic                    core_wen_i,
    input  logic [DATA_WIDTH-1:0]   core_wdata_i,
    input  logic [DATA_WIDTH/8-1:0] core_be_i,
    output logic                    core_gnt_o,
    output logic                    core_rvalid_o,
    output logic [DATA_WIDTH-1:0]   core_rdata_o,
    output logic                    l2_req_o,
    output logic [ADDR_WIDTH-1:0]   l2_addr_o,
    output logic                    l2_wen_o,
    output logic [DATA_WIDTH-1:0]   l2_wdata_o,
    output logic [DATA_WIDTH/8-1:0] l2_be_o,
    input  logic                    l2_gnt_i,
    input  logic                    l2_rvalid_i,
    input  logic [DATA_WIDTH-1:0]   l2_rdata_i,
    output logic                    scm_req_o,
    output logic [ADDR_WIDTH-1:0]   scm_addr_o,
    output logic                    scm_wen_o,
    output logic [DATA_WIDTH-1:0]   scm_wdata_o,
    output logic [DATA_WIDTH/8-1:0] scm_be_o,
    input  logic                    scm_gnt_i,
    input  logic                    scm_rvalid_i,
    input  logic [DATA_WIDTH-1:0]   scm_rdata_i,
    input  logic [31:0]             events_i,
    input  logic                    event_fifo_valid_i,
    input  event_id_t               event_fifo_data_i,
    output logic                    event_fifo_fulln_o,
    output logic                    core_irq_req_o,
    output irq_id_t                 core_irq_id_o,
    input  logic                    core_irq_ack_i,
    input  irq_id_t                 core_irq_ack_id_i,
    output event_id_t               fc_event_data_o,
    input  logic                    core_sleep_i,
    output logic                    core_clock_en_o
);

    logic      fifo_not_empty;
    event_id_t fifo_head;
    logic      fifo_pop;
    logic      any_pending;
    irq_id_t   top_id;
    logic      clear;
    irq_id_t   clear_id;
    logic      timer_en;
    logic      timer_expired;

    tcdm_bus_if core_bus ();
    tcdm_bus_if l2_bus ();
    tcdm_bus_if scm_bus ();

    // **********************************************************
    // Data path, core bus split between L2 and SCM
    // **********************************************************

    assign core_bus.req   = core_req_i;
    assign core_bus.add   = core_addr_i;
    assign core_bus.wen   = core_wen_i;
    assign core_bus.wdata = core_wdata_i;
    assign core_bus.be    = core_be_i;
    assign core_gnt_o     = core_bus.gnt;
    assign core_rvalid_o  = core_bus.r_valid;
    assign core_rdata_o   = core_bus.r_rdata;

    fc_demux fc_demux_data_i (
        .clk_i      ( clk_i    ),
        .rst_n_i    ( rst_n_i  ),
        .slave_port ( core_bus ),
        .l2_port    ( l2_bus   ),
        .scm_port   ( scm_bus  )
    );

    assign l2_req_o        = l2_bus.req;
    assign l2_addr_o       = l2_bus.add;
    assign l2_wen_o        = l2_bus.wen;
    assign l2_wdata_o      = l2_bus.wdata;
    assign l2_be_o         = l2_bus.be;
    assign l2_bus.gnt      = l2_gnt_i;
    assign l2_bus.r_valid  = l2_rvalid_i;
    assign l2_bus.r_rdata  = l2_rdata_i;

    assign scm_req_o       = scm_bus.req;
    assign scm_addr_o      = scm_bus.add;
    assign scm_wen_o       = scm_bus.wen;
    assign scm_wdata_o     = scm_bus.wdata;
    assign scm_be_o        = scm_bus.be;
    assign scm_bus.gnt     = scm_gnt_i;
    assign scm_bus.r_valid = scm_rvalid_i;
    assign scm_bus.r_rdata = scm_rdata_i;

    // **********************************************************
    // Event unit
    // **********************************************************

    event_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) event_fifo_i (
        .clk_i       ( clk_i              ),
        .rst_n_i     ( rst_n_i            ),
        .push_i      ( event_fifo_valid_i ),
        .data_i      ( event_fifo_data_i  ),
        .pop_i       ( fifo_pop           ),
        .not_empty_o ( fifo_not_empty     ),
        .head_o      ( fifo_head          ),
        .fulln_o     ( event_fifo_fulln_o )
    );

    irq_pending irq_pending_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .events_i       ( events_i       ),
        .fifo_pending_i ( fifo_not_empty ),
        .clear_i        ( clear          ),
        .clear_id_i     ( clear_id       ),
        .any_pending_o  ( any_pending    ),
        .top_id_o       ( top_id         )
    );

    irq_ctrl_fsm irq_ctrl_fsm_i (
        .clk_i             ( clk_i             ),
        .rst_n_i           ( rst_n_i           ),
        .any_pending_i     ( any_pending       ),
        .top_id_i          ( top_id            ),
        .fifo_head_i       ( fifo_head         ),
        .core_sleep_i      ( core_sleep_i      ),
        .timer_expired_i   ( timer_expired     ),
        .core_irq_ack_i    ( core_irq_ack_i    ),
        .core_irq_ack_id_i ( core_irq_ack_id_i ),
        .timer_en_o        ( timer_en          ),
        .clear_o           ( clear             ),
        .clear_id_o        ( clear_id          ),
        .fifo_pop_o        ( fifo_pop          ),
        .core_irq_req_o    ( core_irq_req_o    ),
        .core_irq_id_o     ( core_irq_id_o     ),
        .fc_event_data_o   ( fc_event_data_o   ),
        .core_clock_en_o   ( core_clock_en_o   )
    );

    sleep_timer #(
        .SLEEP_DELAY ( SLEEP_DELAY )
    ) sleep_timer_i (
        .clk_i     ( clk_i         ),
        .rst_n_i   ( rst_n_i       ),
        .en_i      ( timer_en      ),
        .expired_o ( timer_expired )
    );

endmodule

/* source/irq_ctrl_fsm.sv */
// Interrupt request and sleep controller
`timescale 1ns/10ps

module irq_ctrl_fsm import fc_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      any_pending_i,
    input  irq_id_t   top_id_i,
    input  event_id_t fifo_head_i,
    input  logic      core_sleep_i,
    input  logic      timer_expired_i,
    input  logic      core_irq_ack_i,
    input  irq_id_t   core_irq_ack_id_i,
    output logic      timer_en_o,
    output logic      clear_o,
    output irq_id_t   clear_id_o,
    output logic      fifo_pop_o,
    output logic      core_irq_req_o,
    output irq_id_t   core_irq_id_o,
    output event_id_t fc_event_data_o,
    output logic      core_clock_en_o
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        SLEEP
    } state_t;

    state_t  state_q;
    irq_id_t irq_id_q;
    logic    clock_en_q;

    // **********************************************************
    // State register
    // **********************************************************

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            irq_id_q   <= '0;
            clock_en_q <= 1'b1;
        end else begin
            case (state_q)
                IDLE: begin
                    if (any_pending_i) begin
                        state_q  <= REQ;
                        irq_id_q <= top_id_i;
                    end else if (core_sleep_i && timer_expired_i) begin
                        state_q    <= SLEEP;
                        clock_en_q <= 1'b0;
                    end
                end
                REQ: begin
                    if (core_irq_ack_i) begin
                        state_q <= IDLE;
                    end
                end
                SLEEP: begin
                    // Wake up straight into the request
                    if (any_pending_i) begin
                        state_q    <= REQ;
                        irq_id_q   <= top_id_i;
                        clock_en_q <= 1'b1;
                    end else if (!core_sleep_i) begin
                        state_q    <= IDLE;
                        clock_en_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // **********************************************************
    // Outputs
    // **********************************************************

    assign timer_en_o = ((state_q == IDLE) && core_sleep_i && !any_pending_i) ||
                        (state_q == SLEEP);

    assign core_irq_req_o  = (state_q == REQ);
    assign core_irq_id_o   = irq_id_q;
    assign core_clock_en_o = clock_en_q;

    // Ack clears the named bit, the FIFO line also pops the head
    assign clear_o    = core_irq_req_o & core_irq_ack_i;
    assign clear_id_o = core_irq_ack_id_i;
    assign fifo_pop_o = clear_o & (core_irq_ack_id_i == FIFO_IRQ_ID);

    assign fc_event_data_o = (core_irq_req_o && (irq_id_q == FIFO_IRQ_ID)) ? fifo_head_i
                                                                            : '0;

    // The core acknowledges the line that is being presented
    a_ack_id_match : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (core_irq_req_o && core_irq_ack_i) |-> (core_irq_ack_id_i == core_irq_id_o));

endmodule

/* source/irq_pending.sv */
// Pending interrupt register
`timescale 1ns/10ps

module irq_pending import fc_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [31:0] events_i,
    input  logic        fifo_pending_i,
    input  logic        clear_i,
    input  irq_id_t     clear_id_i,
    output logic        any_pending_o,
    output irq_id_t     top_id_o
);

    logic [31:0] pending_q;
    logic [31:0] clear_mask;
    logic [31:0] fifo_mask;
    logic [31:0] pending_all;
    irq_id_t     top_id;

    assign clear_mask = clear_i ? (32'b1 << clear_id_i) : 32'b0;

    // Sticky bits, a level still high at the ack sets the bit again
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clear_mask) | events_i;
        end
    end

    // Queued events show up on their own line
    assign fifo_mask   = {31'b0, fifo_pending_i} << FIFO_IRQ_ID;
    assign pending_all = pending_q | fifo_mask;

    // Highest set bit wins
    always_comb begin
        top_id = '0;
        for (int i = 0; i < 32; i++) begin
            if (pending_all[i]) begin
                top_id = irq_id_t'(i);
            end
        end
    end

    assign top_id_o      = top_id;
    assign any_pending_o = |pending_all;

endmodule

/* source/sleep_timer.sv */
// Idle delay counter
`timescale 1ns/10ps

module sleep_timer #(
    parameter int SLEEP_DELAY = 8
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic en_i,
    output logic expired_o
);

    localparam int CNT_W = $clog2(SLEEP_DELAY + 1);
    // Counting from zero, the last enabled cycle sits at the limit
    localparam logic [CNT_W-1:0] LIMIT = CNT_W'(SLEEP_DELAY - 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (!en_i) begin
            cnt_q <= '0;
        end else if (cnt_q != LIMIT) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Held high for as long as enable stays up
    assign expired_o = en_i && (cnt_q == LIMIT);

endmodule

/* source/tcdm_bus_if.sv */
// Memory request and response bus
`timescale 1ns/10ps

interface tcdm_bus_if import fc_pkg::*; ();

    // Request channel
    logic                    req;
    logic [ADDR_WIDTH-1:0]   add;
    logic                    wen;
    logic [DATA_WIDTH-1:0]   wdata;
    logic [DATA_WIDTH/8-1:0] be;

    // Grant and read response
    logic                    gnt;
    logic                    r_valid;
    logic [DATA_WIDTH-1:0]   r_rdata;

    modport master (
        output req, add, wen, wdata, be,
        input  gnt, r_valid, r_rdata
    );

    modport slave (
        input  req, add, wen, wdata, be,
        output gnt, r_valid, r_rdata
    );

endinterface

/* tb/fc_subsystem_input.txt */
# rd addr exp_scm exp_rdata | ev mask | push id | irq exp_id exp_event_data | sleep exp_cycles
# full exp_fulln | clk exp_clock_en | req exp_irq_req | awake, all values in hex
clk 1
full 1
req 0
rd 1C000100 1 DFC3C2C3
rd 10007FFC 1 D3C3BC3F
rd 1C008000 0 465ADA5A
rd 1A000040 0 405A5A1A
ev 00000004
irq 02 00
ev 00020008
irq 11 00
irq 03 00
push 11
push 22
push 33
irq 1A 11
irq 1A 22
irq 1A 33
push A0
push A1
push A2
push A3
full 0
push A4
irq 1A A0
irq 1A A1
irq 1A A2
irq 1A A3
full 1
req 0
sleep 8
clk 0
ev 00000100
irq 08 00
awake
clk 1
req 0

/* tb/tb_fc_subsystem.sv */
// Fabric controller subsystem testbench
`timescale 1ns/10ps

module tb_fc_subsystem import fc_pkg::*; ();

    localparam int    FIFO_DEPTH    = 4;
    localparam int    SLEEP_DELAY   = 8;
    localparam int    CLK_HALF      = 20;
    localparam int    CYCLES_PER_OP = 40;
    localparam string STIM_FILE     = "tb/fc_subsystem_input.txt";

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    core_req_i;
    logic [ADDR_WIDTH-1:0]   core_addr_i;
    logic                    core_wen_i;
    logic [DATA_WIDTH-1:0]   core_wdata_i;
    logic [DATA_WIDTH/8-1:0] core_be_i;
    logic                    core_gnt_o;
    logic                    core_rvalid_o;
    logic [DATA_WIDTH-1:0]   core_rdata_o;
    logic                    l2_req_o;
    logic [ADDR_WIDTH-1:0]   l2_addr_o;
    logic                    l2_wen_o;
    logic [DATA_WIDTH-1:0]   l2_wdata_o;
    logic [DATA_WIDTH/8-1:0] l2_be_o;
    logic                    l2_gnt_i;
    logic                    l2_rvalid_i;
    logic [DATA_WIDTH-1:0]   l2_rdata_i;
    logic                    scm_req_o;
    logic [ADDR_WIDTH-1:0]   scm_addr_o;
    logic                    scm_wen_o;
    logic [DATA_WIDTH-1:0]   scm_wdata_o;
    logic [DATA_WIDTH/8-1:0] scm_be_o;
    logic                    scm_gnt_i;
    logic                    scm_rvalid_i;
    logic [DATA_WIDTH-1:0]   scm_rdata_i;
    logic [31:0]             events_i;
    logic                    event_fifo_valid_i;
    event_id_t               event_fifo_data_i;
    logic                    event_fifo_fulln_o;
    logic                    core_irq_req_o;
    irq_id_t                 core_irq_id_o;
    logic                    core_irq_ack_i;
    irq_id_t                 core_irq_ack_id_i;
    event_id_t               fc_event_data_o;
    logic                    core_sleep_i;
    logic                    core_clock_en_o;

    // Memory model state, one accepted request per port
    logic        l2_acc_q;
    logic [31:0] l2_addr_q;
    logic        scm_acc_q;
    logic [31:0] scm_addr_q;

    int fd;
    int checks_done  = 0;
    int value_errors = 0;
    int other_errors = 0;
    int cycle_cnt    = 0;
    int cycle_limit  = 0;

    fc_subsystem #(
        .FIFO_DEPTH  ( FIFO_DEPTH  ),
        .SLEEP_DELAY ( SLEEP_DELAY )
    ) dut0 (.*);

    always #CLK_HALF clk_i = ~clk_i;

    // **********************************************************
    // Memory models, grant at once and answer one cycle later
    // **********************************************************

    function automatic logic [31:0] l2_word(input logic [31:0] addr);
        return addr ^ 32'h5A5A_5A5A;
    endfunction

    function automatic logic [31:0] scm_word(input logic [31:0] addr);
        return addr ^ 32'hC3C3_C3C3;
    endfunction

    always @(posedge clk_i) begin
        l2_acc_q   <= l2_req_o & l2_gnt_i;
        l2_addr_q  <= l2_addr_o;
        scm_acc_q  <= scm_req_o & scm_gnt_i;
        scm_addr_q <= scm_addr_o;
    end

    always @(negedge clk_i) begin
        l2_rvalid_i  = l2_acc_q;
        l2_rdata_i   = l2_acc_q ? l2_word(l2_addr_q) : '0;
        scm_rvalid_i = scm_acc_q;
        scm_rdata_i  = scm_acc_q ? scm_word(scm_addr_q) : '0;
    end

    // **********************************************************
    // Compare tasks and run control
    // **********************************************************

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks_done++;
        if (got !== exp) begin
            $display("error %s: got 0x%h expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks_done++;
        if (got !== exp) begin
            $display("error %s: got 0x%h expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_irq_id(input string name, input irq_id_t got, input irq_id_t exp);
        checks_done++;
        if (got !== exp) begin
            $display("error %s: got 0x%h expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_event_id(input string name, input event_id_t got,
                                  input event_id_t exp);
        checks_done++;
        if (got !== exp) begin
            $display("error %s: got 0x%h expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks_done, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            other_errors++;
            finish_run();
        end
    end

    // **********************************************************
    // Core side operations
    // **********************************************************

    task automatic bus_read(input logic [31:0] addr, input logic exp_scm,
                            input logic [31:0] exp_data);
        logic [DATA_WIDTH-1:0]   wdata;
        logic [DATA_WIDTH/8-1:0] be;
        wdata = ~addr;
        be    = addr[11:8] ^ 4'h5;
        @(negedge clk_i);
        core_req_i   = 1'b1;
        core_addr_i  = addr;
        core_wen_i   = 1'b1;
        core_wdata_i = wdata;
        core_be_i    = be;
        @(posedge clk_i);
        check_bit("scm_req_o", scm_req_o, exp_scm);
        check_bit("l2_req_o", l2_req_o, !exp_scm);
        // Request fields reach the chosen memory unchanged
        if (exp_scm) begin
            check_word("scm_addr_o", scm_addr_o, addr);
            check_bit("scm_wen_o", scm_wen_o, 1'b1);
            check_word("scm_wdata_o", scm_wdata_o, wdata);
            check_word("scm_be_o", 32'(scm_be_o), 32'(be));
        end else begin
            check_word("l2_addr_o", l2_addr_o, addr);
            check_bit("l2_wen_o", l2_wen_o, 1'b1);
            check_word("l2_wdata_o", l2_wdata_o, wdata);
            check_word("l2_be_o", 32'(l2_be_o), 32'(be));
        end
        check_bit("core_rvalid_o", core_rvalid_o, 1'b0);
        while (core_gnt_o !== 1'b1) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
        core_req_i = 1'b0;
        // Response is due exactly one cycle after acceptance
        @(posedge clk_i);
        check_bit("core_rvalid_o", core_rvalid_o, 1'b1);
        check_word("core_rdata_o", core_rdata_o, exp_data);
        check_bit("core_gnt_o", core_gnt_o, 1'b0);
    endtask

    task automatic raise_events(input logic [31:0] mask);
        @(negedge clk_i);
        events_i = mask;
        @(negedge clk_i);
        events_i = '0;
    endtask

    task automatic push_event(input event_id_t id);
        @(negedge clk_i);
        event_fifo_valid_i = 1'b1;
        event_fifo_data_i  = id;
        @(negedge clk_i);
        event_fifo_valid_i = 1'b0;
    endtask

    task automatic take_irq(input irq_id_t exp_id, input event_id_t exp_data);
        @(posedge clk_i);
        while (core_irq_req_o !== 1'b1) begin
            @(posedge clk_i);
        end
        check_irq_id("core_irq_id_o", core_irq_id_o, exp_id);
        check_event_id("fc_event_data_o", fc_event_data_o, exp_data);
        check_bit("core_clock_en_o", core_clock_en_o, 1'b1);
        // The core acknowledges the line it was given
        @(negedge clk_i);
        core_irq_ack_i    = 1'b1;
        core_irq_ack_id_i = core_irq_id_o;
        @(negedge clk_i);
        core_irq_ack_i = 1'b0;
        @(posedge clk_i);
        check_bit("core_irq_req_o", core_irq_req_o, 1'b0);
    endtask

    // Counts the edges that still see the clock enabled
    task automatic measure_sleep(input logic [31:0] exp_cycles);
        int n;
        n = 0;
        @(negedge clk_i);
        core_sleep_i = 1'b1;
        @(posedge clk_i);
        while (core_clock_en_o === 1'b1) begin
            n++;
            @(posedge clk_i);
        end
        check_word("core_clock_en_o high cycles", 32'(n), exp_cycles);
    endtask

    task automatic report_bad_step(input string op);
        $display("Stimulus line for opcode %s has missing operands", op);
        other_errors++;
    endtask

    task automatic run_step(input string op);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int          code;
        if (op == "rd") begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            if (code != 3) report_bad_step(op);
            else bus_read(a, b[0], c);
        end else if (op == "ev") begin
            code = $fscanf(fd, "%h", a);
            if (code != 1) report_bad_step(op);
            else raise_events(a);
        end else if (op == "push") begin
            code = $fscanf(fd, "%h", a);
            if (code != 1) report_bad_step(op);
            else push_event(a[EVENT_ID_WIDTH-1:0]);
        end else if (op == "irq") begin
            code = $fscanf(fd, "%h %h", a, b);
            if (code != 2) report_bad_step(op);
            else take_irq(a[IRQ_ID_WIDTH-1:0], b[EVENT_ID_WIDTH-1:0]);
        end else if (op == "sleep") begin
            code = $fscanf(fd, "%h", a);
            if (code != 1) report_bad_step(op);
            else measure_sleep(a);
        end else if (op == "awake") begin
            @(negedge clk_i);
            core_sleep_i = 1'b0;
        end else if (op == "full" || op == "clk" || op == "req") begin
            code = $fscanf(fd, "%h", a);
            @(posedge clk_i);
            if (code != 1) report_bad_step(op);
            else if (op == "full") check_bit("event_fifo_fulln_o", event_fifo_fulln_o, a[0]);
            else if (op == "clk") check_bit("core_clock_en_o", core_clock_en_o, a[0]);
            else check_bit("core_irq_req_o", core_irq_req_o, a[0]);
        end else begin
            $display("Unknown opcode %s in stimulus file", op);
            other_errors++;
        end
    endtask

    initial begin
        string line;
        string op;
        int    code;
        int    steps;
        logic  done;
        clk_i              = 1'b0;
        rst_n_i            = 1'b0;
        core_req_i         = 1'b0;
        core_addr_i        = '0;
        core_wen_i         = 1'b1;
        core_wdata_i       = '0;
        core_be_i          = '1;
        l2_gnt_i           = 1'b1;
        l2_rvalid_i        = 1'b0;
        l2_rdata_i         = '0;
        scm_gnt_i          = 1'b1;
        scm_rvalid_i       = 1'b0;
        scm_rdata_i        = '0;
        events_i           = '0;
        event_fifo_valid_i = 1'b0;
        event_fifo_data_i  = '0;
        core_irq_ack_i     = 1'b0;
        core_irq_ack_id_i  = '0;
        core_sleep_i       = 1'b0;
        steps              = 0;
        done               = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open stimulus file %s", STIM_FILE);
            other_errors++;
            finish_run();
        end else begin
            // First pass sizes the timeout
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    steps++;
                end
            end
            $fclose(fd);
            cycle_limit = CYCLES_PER_OP * steps + 4;
            fd = $fopen(STIM_FILE, "r");
            repeat (2) @(posedge clk_i);
            @(negedge clk_i);
            rst_n_i = 1'b1;
            while (!done) begin
                code = $fscanf(fd, "%s", op);
                if (code != 1) begin
                    done = 1'b1;
                end else if (op.getc(0) == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    run_step(op);
                end
            end
            $fclose(fd);
            finish_run();
        end
    end

endmodule
